//--- tlul_pkg.sv
package tlul_pkg;

  // bus widths
  localparam int unsigned TL_AW  = 32;
  localparam int unsigned TL_DW  = 32;
  localparam int unsigned TL_DBW = TL_DW / 8;
  localparam int unsigned TL_AIW = 8;

  // source id split: port prefix on top, rolling count below
  localparam int unsigned TL_PREFIX_W  = 3;
  localparam int unsigned TL_SRC_CNT_W = TL_AIW - TL_PREFIX_W;

  // log2 of the beat size in bytes, always a full word here
  localparam logic [1:0] TL_SIZE_WORD = 2'd2;

  // a channel opcodes
  typedef enum logic [2:0] {
    PutFullData    = 3'h0,
    PutPartialData = 3'h1,
    Get            = 3'h4
  } tl_a_op_e;

  // d channel opcodes
  typedef enum logic [2:0] {
    AccessAck     = 3'h0,
    AccessAckData = 3'h1
  } tl_d_op_e;

  // host to device, a channel plus d_ready
  typedef struct packed {
    logic                a_valid;
    tl_a_op_e            a_opcode;
    logic [1:0]          a_size;
    logic [TL_AIW-1:0]   a_source;
    logic [TL_AW-1:0]    a_address;
    logic [TL_DBW-1:0]   a_mask;
    logic [TL_DW-1:0]    a_data;
    logic                d_ready;
  } tl_h2d_t;

  // device to host, d channel plus a_ready
  typedef struct packed {
    logic                d_valid;
    tl_d_op_e            d_opcode;
    logic [TL_AIW-1:0]   d_source;
    logic [TL_DW-1:0]    d_data;
    logic                d_error;
    logic                a_ready;
  } tl_d2h_t;

  // one request waiting for its response
  typedef struct packed {
    logic              is_write;
    logic [TL_AIW-1:0] source;
  } outst_entry_t;

endpackage

//--- tlul_outstanding_fifo.sv
`timescale 1ns/1ns

module tlul_outstanding_fifo import tlul_pkg::*; #(
  parameter int unsigned MAX_REQS = 2
) (
  input  logic         clk_i,
  input  logic         rst_i,
  input  logic         push_i,
  input  outst_entry_t push_entry_i,
  input  logic         pop_i,
  output outst_entry_t head_o,
  output logic         full_o,
  output logic         empty_o
);

  // a single entry still needs a one bit pointer
  localparam int unsigned PTR_W = (MAX_REQS > 1) ? $clog2(MAX_REQS) : 1;
  localparam int unsigned CNT_W = $clog2(MAX_REQS + 1);

  outst_entry_t     mem_q [MAX_REQS];
  logic [PTR_W-1:0] wr_ptr_q;
  logic [PTR_W-1:0] rd_ptr_q;
  logic [CNT_W-1:0] count_q;
  logic             push_ok;
  logic             pop_ok;

  assign empty_o = (count_q == '0);
  assign full_o  = (count_q == CNT_W'(MAX_REQS));
  assign head_o  = mem_q[rd_ptr_q];

  // a pop frees the slot that a push in the same cycle may take
  assign pop_ok  = pop_i & ~empty_o;
  assign push_ok = push_i & (~full_o | pop_ok);

  always_ff @(posedge clk_i) begin
    if (push_ok) begin
      mem_q[wr_ptr_q] <= push_entry_i;
    end
  end

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (push_ok) begin
        wr_ptr_q <= (wr_ptr_q == PTR_W'(MAX_REQS - 1)) ? '0 : wr_ptr_q + 1'b1;
      end
      if (pop_ok) begin
        rd_ptr_q <= (rd_ptr_q == PTR_W'(MAX_REQS - 1)) ? '0 : rd_ptr_q + 1'b1;
      end
      // occupancy only moves when exactly one side is active
      if (push_ok && !pop_ok) begin
        count_q <= count_q + 1'b1;
      end else if (pop_ok && !push_ok) begin
        count_q <= count_q - 1'b1;
      end
    end
  end

endmodule

//--- tlul_rsp_check.sv
`timescale 1ns/1ns

module tlul_rsp_check import tlul_pkg::*; (
  input  logic              d_valid_i,
  input  tl_d_op_e          d_opcode_i,
  input  logic [TL_AIW-1:0] d_source_i,
  input  logic [TL_DW-1:0]  d_data_i,
  input  logic              d_error_i,
  input  outst_entry_t      head_i,
  input  logic              empty_i,
  output logic              rvalid_o,
  output logic [TL_DW-1:0]  rdata_o,
  output logic              err_o
);

  tl_d_op_e exp_opcode;
  logic     src_mismatch;
  logic     op_mismatch;

  // reads expect data back, writes a plain ack
  assign exp_opcode   = head_i.is_write ? AccessAck : AccessAckData;
  assign src_mismatch = (d_source_i != head_i.source);
  assign op_mismatch  = (d_opcode_i != exp_opcode);

  assign rvalid_o = d_valid_i;

  always_comb begin
    err_o   = 1'b0;
    rdata_o = '0;
    if (d_valid_i) begin
      // stray beat with nothing outstanding is an error too
      err_o = d_error_i | empty_i | src_mismatch | op_mismatch;
      if (!err_o && !head_i.is_write) begin
        rdata_o = d_data_i;
      end
    end
  end

endmodule

//--- tlul_host_adapter.sv
`timescale 1ns/1ns

module tlul_host_adapter import tlul_pkg::*; #(
  parameter int unsigned           MAX_REQS   = 2,
  parameter logic [TL_PREFIX_W-1:0] SRC_PREFIX = '0
) (
  input  logic              clk_i,
  input  logic              rst_i,

  // core side
  input  logic              req_i,
  output logic              gnt_o,
  input  logic [TL_AW-1:0]  addr_i,
  input  logic              we_i,
  input  logic [TL_DBW-1:0] be_i,
  input  logic [TL_DW-1:0]  wdata_i,
  output logic              rvalid_o,
  output logic [TL_DW-1:0]  rdata_o,
  output logic              err_o,

  // bus side
  input  tl_d2h_t           tl_i,
  output tl_h2d_t           tl_o
);

  logic                    active_q;
  logic [TL_SRC_CNT_W-1:0] src_cnt_q;
  logic [TL_AIW-1:0]       a_source;
  tl_a_op_e                a_opcode;
  logic                    a_valid;
  logic                    d_beat;
  logic                    fifo_full;
  logic                    fifo_empty;
  outst_entry_t            push_entry;
  outst_entry_t            head;

  // set one cycle after reset is released
  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      active_q <= 1'b0;
    end else begin
      active_q <= 1'b1;
    end
  end

  // d_ready is always high once active, so any valid beat transfers
  assign d_beat = active_q & tl_i.d_valid;

  // a response this cycle frees room for a new grant
  assign a_valid = active_q & req_i & (~fifo_full | d_beat);
  assign gnt_o   = a_valid & tl_i.a_ready;

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      src_cnt_q <= '0;
    end else if (gnt_o) begin
      src_cnt_q <= src_cnt_q + 1'b1;
    end
  end

  assign a_source = {SRC_PREFIX, src_cnt_q};

  always_comb begin
    if (!we_i) begin
      a_opcode = Get;
    end else if (&be_i) begin
      a_opcode = PutFullData;
    end else begin
      a_opcode = PutPartialData;
    end
  end

  always_comb begin
    tl_o           = '0;
    tl_o.a_valid   = a_valid;
    tl_o.a_opcode  = a_opcode;
    tl_o.a_size    = TL_SIZE_WORD;
    tl_o.a_source  = a_source;
    tl_o.a_address = {addr_i[TL_AW-1:2], 2'b00};
    tl_o.a_mask    = be_i;
    tl_o.a_data    = wdata_i;
    tl_o.d_ready   = active_q;
  end

  assign push_entry.is_write = we_i;
  assign push_entry.source   = a_source;

  tlul_outstanding_fifo #(
    .MAX_REQS (MAX_REQS)
  ) u_outst_fifo (
    .clk_i        (clk_i),
    .rst_i        (rst_i),
    .push_i       (gnt_o),
    .push_entry_i (push_entry),
    .pop_i        (d_beat),
    .head_o       (head),
    .full_o       (fifo_full),
    .empty_o      (fifo_empty)
  );

  tlul_rsp_check u_rsp_check (
    .d_valid_i  (d_beat),
    .d_opcode_i (tl_i.d_opcode),
    .d_source_i (tl_i.d_source),
    .d_data_i   (tl_i.d_data),
    .d_error_i  (tl_i.d_error),
    .head_i     (head),
    .empty_i    (fifo_empty),
    .rvalid_o   (rvalid_o),
    .rdata_o    (rdata_o),
    .err_o      (err_o)
  );

endmodule

//--- tlul_host_wrapper.sv
`timescale 1ns/1ns

module tlul_host_wrapper import tlul_pkg::*; #(
  parameter int unsigned MAX_REQS = 2
) (
  input  logic              clk_i,
  input  logic              rst_i,

  // instruction port, read only
  input  logic              instr_req_i,
  output logic              instr_gnt_o,
  input  logic [TL_AW-1:0]  instr_addr_i,
  output logic              instr_rvalid_o,
  output logic [TL_DW-1:0]  instr_rdata_o,
  output logic              instr_err_o,
  input  tl_d2h_t           tl_i_i,
  output tl_h2d_t           tl_i_o,

  // data port
  input  logic              data_req_i,
  output logic              data_gnt_o,
  input  logic              data_we_i,
  input  logic [TL_DBW-1:0] data_be_i,
  input  logic [TL_AW-1:0]  data_addr_i,
  input  logic [TL_DW-1:0]  data_wdata_i,
  output logic              data_rvalid_o,
  output logic [TL_DW-1:0]  data_rdata_o,
  output logic              data_err_o,
  input  tl_d2h_t           tl_d_i,
  output tl_h2d_t           tl_d_o
);

  // fetches are full-word reads
  tlul_host_adapter #(
    .MAX_REQS   (MAX_REQS),
    .SRC_PREFIX (3'd0)
  ) u_instr_adapter (
    .clk_i    (clk_i),
    .rst_i    (rst_i),
    .req_i    (instr_req_i),
    .gnt_o    (instr_gnt_o),
    .addr_i   (instr_addr_i),
    .we_i     (1'b0),
    .be_i     ({TL_DBW{1'b1}}),
    .wdata_i  ({TL_DW{1'b0}}),
    .rvalid_o (instr_rvalid_o),
    .rdata_o  (instr_rdata_o),
    .err_o    (instr_err_o),
    .tl_i     (tl_i_i),
    .tl_o     (tl_i_o)
  );

  tlul_host_adapter #(
    .MAX_REQS   (MAX_REQS),
    .SRC_PREFIX (3'd1)
  ) u_data_adapter (
    .clk_i    (clk_i),
    .rst_i    (rst_i),
    .req_i    (data_req_i),
    .gnt_o    (data_gnt_o),
    .addr_i   (data_addr_i),
    .we_i     (data_we_i),
    .be_i     (data_be_i),
    .wdata_i  (data_wdata_i),
    .rvalid_o (data_rvalid_o),
    .rdata_o  (data_rdata_o),
    .err_o    (data_err_o),
    .tl_i     (tl_d_i),
    .tl_o     (tl_d_o)
  );

endmodule

//--- tb_tlul_checker.sv
`timescale 1ns/1ns

module tb_tlul_checker import tlul_pkg::*; #(
  parameter int MAX_REQS = 2
) (
  input logic        clk_i,
  input logic        rst_i,
  input logic [31:0] instr_addr_i,
  input logic        instr_gnt_i,
  input logic        instr_rvalid_i,
  input logic [31:0] instr_rdata_i,
  input logic        instr_err_i,
  input tl_h2d_t     instr_tl_i,
  input logic [31:0] data_addr_i,
  input logic        data_we_i,
  input logic [3:0]  data_be_i,
  input logic [31:0] data_wdata_i,
  input logic        data_gnt_i,
  input logic        data_rvalid_i,
  input logic [31:0] data_rdata_i,
  input logic        data_err_i,
  input tl_h2d_t     data_tl_i
);

  // shadow copies of the two device memories
  logic [31:0] instr_mem [256];
  logic [31:0] data_mem [256];
  // expected {err, rdata} in request order
  logic [32:0] exp_i [$];
  logic [32:0] exp_d [$];
  logic [32:0] exp;
  logic        rst_q = 1'b0;
  int          errors = 0;
  int          gnt_cnt_i = 0;
  int          gnt_cnt_d = 0;
  int          rsp_cnt_i = 0;
  int          rsp_cnt_d = 0;

  initial begin
    for (int i = 0; i < 256; i++) begin
      instr_mem[i] = i ^ 32'h5a3c_96e1;
      data_mem[i]  = i ^ 32'h5a3c_96e1;
    end
  end

  function automatic logic [32:0] ref_access(input logic port_d, input logic [31:0] addr,
                                             input logic we, input logic [3:0] be,
                                             input logic [31:0] wdata);
    logic [31:0] word;
    logic [7:0]  idx;
    idx = addr[9:2];
    if (addr[31]) begin
      return {1'b1, 32'h0};
    end
    if (!we) begin
      return {1'b0, port_d ? data_mem[idx] : instr_mem[idx]};
    end
    word = data_mem[idx];
    for (int b = 0; b < 4; b++) begin
      if (be[b]) begin
        word[b*8 +: 8] = wdata[b*8 +: 8];
      end
    end
    data_mem[idx] = word;
    return {1'b0, 32'h0};
  endfunction

  task automatic fail(input string msg);
    errors++;
    $display("FAILED at %0t: %s", $time, msg);
  endtask

  task automatic check_balance();
    if (gnt_cnt_i != rsp_cnt_i || gnt_cnt_d != rsp_cnt_d) begin
      fail($sformatf("grant and response counts differ, instr %0d/%0d data %0d/%0d",
                     gnt_cnt_i, rsp_cnt_i, gnt_cnt_d, rsp_cnt_d));
    end
  endtask

  // source is the port prefix over the count of earlier grants
  task automatic check_a_beat(input string port, input tl_h2d_t tl, input logic [2:0] prefix,
                              input int cnt, input logic [31:0] addr, input logic we,
                              input logic [3:0] be, input logic [31:0] wdata);
    tl_a_op_e op;
    if (!we) begin
      op = Get;
    end else if (be == 4'hf) begin
      op = PutFullData;
    end else begin
      op = PutPartialData;
    end
    if (tl.a_opcode != op || tl.a_size != 2'd2 || tl.a_source != {prefix, 5'(cnt)} ||
        tl.a_address != (addr & 32'hffff_fffc) || tl.a_mask != be || tl.a_data != wdata) begin
      fail($sformatf("%s A beat opcode=%0d size=%0d source=%h address=%h mask=%h data=%h",
                     port, tl.a_opcode, tl.a_size, tl.a_source, tl.a_address, tl.a_mask,
                     tl.a_data));
    end
  endtask

  always @(posedge clk_i) begin
    if (rst_q && (instr_gnt_i || instr_rvalid_i || instr_tl_i.a_valid || instr_tl_i.d_ready ||
                  data_gnt_i || data_rvalid_i || data_tl_i.a_valid || data_tl_i.d_ready)) begin
      fail("handshake signal high right after reset");
    end
    rst_q <= rst_i;
    if (!rst_i) begin
      // responses leave the queue before new grants enter it
      if (instr_rvalid_i) begin
        rsp_cnt_i++;
        if (exp_i.size() == 0) begin
          errors++;
          $display("instruction port returned a response with no request pending");
        end else begin
          exp = exp_i.pop_front();
          if ({instr_err_i, instr_rdata_i} != exp) begin
            fail($sformatf("instr got err=%0b rdata=%h, expected err=%0b rdata=%h",
                           instr_err_i, instr_rdata_i, exp[32], exp[31:0]));
          end
        end
      end
      if (data_rvalid_i) begin
        rsp_cnt_d++;
        if (exp_d.size() == 0) begin
          errors++;
          $display("data port returned a response with no request pending");
        end else begin
          exp = exp_d.pop_front();
          if ({data_err_i, data_rdata_i} != exp) begin
            fail($sformatf("data got err=%0b rdata=%h, expected err=%0b rdata=%h",
                           data_err_i, data_rdata_i, exp[32], exp[31:0]));
          end
        end
      end
      if (instr_gnt_i) begin
        check_a_beat("instr", instr_tl_i, 3'd0, gnt_cnt_i, instr_addr_i, 1'b0, 4'hf, '0);
        gnt_cnt_i++;
        exp_i.push_back(ref_access(1'b0, instr_addr_i, 1'b0, 4'hf, '0));
      end
      if (data_gnt_i) begin
        check_a_beat("data", data_tl_i, 3'd1, gnt_cnt_d, data_addr_i, data_we_i,
                     data_be_i, data_wdata_i);
        gnt_cnt_d++;
        exp_d.push_back(ref_access(1'b1, data_addr_i, data_we_i, data_be_i, data_wdata_i));
      end
      if (exp_i.size() > MAX_REQS || exp_d.size() > MAX_REQS) begin
        fail("more requests in flight than MAX_REQS");
      end
    end
  end

endmodule

//--- tb_tlul_host_wrapper.sv
`timescale 1ns/1ns

// simple word memory behind one TL-UL host port
module tl_mem_device import tlul_pkg::*; #(
  parameter int SEED_OFS = 0
) (
  input  logic    clk_i,
  input  logic    rst_i,
  input  logic    max_delay_i,
  input  tl_h2d_t tl_i,
  output tl_d2h_t tl_o
);

  typedef struct packed {
    logic [TL_AIW-1:0] source;
    tl_d_op_e          opcode;
    logic [TL_DW-1:0]  data;
    logic              error;
    int                due;
  } rsp_t;

  logic [31:0] mem [256];
  rsp_t        rsp_q [$];
  rsp_t        rsp;
  tl_d2h_t     tl_q = '0;
  int          cycle;
  int          dly;
  int          pending = 0;
  integer      seed;

  assign tl_o = tl_q;

  initial begin
    seed = 39451 + SEED_OFS;
    for (int i = 0; i < 256; i++) begin
      mem[i] = i ^ 32'h5a3c_96e1;
    end
  end

  always @(posedge clk_i) begin
    if (rst_i) begin
      rsp_q.delete();
      cycle = 0;
      pending = 0;
    end else begin
      if (tl_q.d_valid && tl_i.d_ready) begin
        void'(rsp_q.pop_front());
      end
      if (tl_i.a_valid && tl_q.a_ready) begin
        dly = max_delay_i ? 3 : ($random(seed) & 3);
        rsp.source = tl_i.a_source;
        rsp.error  = tl_i.a_address[31];
        rsp.due    = cycle + 1 + dly;
        rsp.data   = '0;
        if (tl_i.a_opcode == Get) begin
          rsp.opcode = AccessAckData;
          if (!rsp.error) begin
            rsp.data = mem[tl_i.a_address[9:2]];
          end
        end else begin
          rsp.opcode = AccessAck;
          // error region leaves the memory alone
          for (int b = 0; b < 4; b++) begin
            if (tl_i.a_mask[b] && !rsp.error) begin
              mem[tl_i.a_address[9:2]][b*8 +: 8] = tl_i.a_data[b*8 +: 8];
            end
          end
        end
        rsp_q.push_back(rsp);
      end
      pending = rsp_q.size();
      cycle++;
    end
  end

  always @(negedge clk_i) begin
    tl_q.a_ready = (($random(seed) & 3) != 0);
    if (rst_i || rsp_q.size() == 0 || rsp_q[0].due > cycle) begin
      tl_q.d_valid = 1'b0;
    end else begin
      tl_q.d_valid  = 1'b1;
      tl_q.d_opcode = rsp_q[0].opcode;
      tl_q.d_source = rsp_q[0].source;
      tl_q.d_data   = rsp_q[0].data;
      tl_q.d_error  = rsp_q[0].error;
    end
  end

endmodule

module tb_tlul_host_wrapper import tlul_pkg::*; ();

  localparam int MAX_REQS = 2;
  // 40 + 80 + 60 + 40 + 16 transactions
  localparam int NUM_TXNS = 236;
  localparam int LIMIT    = NUM_TXNS * 12 + 200;

  logic        clk = 1'b0;
  logic        rst = 1'b1;
  // requests held high through reset so the gating is exercised
  logic        instr_req = 1'b1;
  logic [31:0] instr_addr = '0;
  logic        instr_gnt;
  logic        instr_rvalid;
  logic [31:0] instr_rdata;
  logic        instr_err;
  logic        data_req = 1'b1;
  logic        data_we = 1'b0;
  logic [3:0]  data_be = '0;
  logic [31:0] data_addr = '0;
  logic [31:0] data_wdata = '0;
  logic        data_gnt;
  logic        data_rvalid;
  logic [31:0] data_rdata;
  logic        data_err;
  logic        max_delay = 1'b0;
  tl_d2h_t     tl_i_d2h;
  tl_h2d_t     tl_i_h2d;
  tl_d2h_t     tl_d_d2h;
  tl_h2d_t     tl_d_h2d;
  integer      seed;
  int          cycles = 0;
  int          tests = 0;
  int          tests_failed = 0;
  int          err_mark;

  always #5 clk = ~clk;

  tlul_host_wrapper #(
    .MAX_REQS (MAX_REQS)
  ) u_tlul_host_wrapper (
    .clk_i          (clk),
    .rst_i          (rst),
    .instr_req_i    (instr_req),
    .instr_gnt_o    (instr_gnt),
    .instr_addr_i   (instr_addr),
    .instr_rvalid_o (instr_rvalid),
    .instr_rdata_o  (instr_rdata),
    .instr_err_o    (instr_err),
    .tl_i_i         (tl_i_d2h),
    .tl_i_o         (tl_i_h2d),
    .data_req_i     (data_req),
    .data_gnt_o     (data_gnt),
    .data_we_i      (data_we),
    .data_be_i      (data_be),
    .data_addr_i    (data_addr),
    .data_wdata_i   (data_wdata),
    .data_rvalid_o  (data_rvalid),
    .data_rdata_o   (data_rdata),
    .data_err_o     (data_err),
    .tl_d_i         (tl_d_d2h),
    .tl_d_o         (tl_d_h2d)
  );

  tl_mem_device #(.SEED_OFS(0)) u_instr_mem (
    .clk_i (clk), .rst_i (rst), .max_delay_i (max_delay),
    .tl_i (tl_i_h2d), .tl_o (tl_i_d2h)
  );

  tl_mem_device #(.SEED_OFS(1)) u_data_mem (
    .clk_i (clk), .rst_i (rst), .max_delay_i (max_delay),
    .tl_i (tl_d_h2d), .tl_o (tl_d_d2h)
  );

  tb_tlul_checker #(.MAX_REQS(MAX_REQS)) u_checker (
    .clk_i          (clk),
    .rst_i          (rst),
    .instr_addr_i   (instr_addr),
    .instr_gnt_i    (instr_gnt),
    .instr_rvalid_i (instr_rvalid),
    .instr_rdata_i  (instr_rdata),
    .instr_err_i    (instr_err),
    .instr_tl_i     (tl_i_h2d),
    .data_addr_i    (data_addr),
    .data_we_i      (data_we),
    .data_be_i      (data_be),
    .data_wdata_i   (data_wdata),
    .data_gnt_i     (data_gnt),
    .data_rvalid_i  (data_rvalid),
    .data_rdata_i   (data_rdata),
    .data_err_i     (data_err),
    .data_tl_i      (tl_d_h2d)
  );

  always @(posedge clk) begin
    cycles++;
    if (cycles >= LIMIT) begin
      $display("timeout: run did not finish within %0d cycles", LIMIT);
      $display("TEST RESULT: FAIL");
      $finish;
    end
  end

  // random byte offset within the word exercises address alignment
  function automatic logic [31:0] rand_word_addr();
    logic [31:0] r;
    r = $random(seed);
    return {22'b0, r[7:0], r[9:8]};
  endfunction

  task automatic instr_read(input logic [31:0] addr);
    instr_req  = 1'b1;
    instr_addr = addr;
    do @(posedge clk); while (!instr_gnt);
    @(negedge clk);
    instr_req = 1'b0;
  endtask

  task automatic data_access(input logic we, input logic [31:0] addr,
                             input logic [3:0] be, input logic [31:0] wdata);
    data_req   = 1'b1;
    data_we    = we;
    data_addr  = addr;
    data_be    = be;
    data_wdata = wdata;
    do @(posedge clk); while (!data_gnt);
    @(negedge clk);
    data_req = 1'b0;
  endtask

  // both device models have answered every accepted request
  task automatic wait_idle();
    while (u_instr_mem.pending != 0 || u_data_mem.pending != 0) begin
      @(negedge clk);
    end
  endtask

  task automatic end_test(input string name);
    tests++;
    if (u_checker.errors != err_mark) begin
      tests_failed++;
    end
    $display("test %s finished with %0d errors", name, u_checker.errors - err_mark);
    err_mark = u_checker.errors;
  endtask

  initial begin
    logic [31:0] a;
    seed = 39451;
    err_mark = 0;
    repeat (8) @(negedge clk);
    rst = 1'b0;
    instr_req = 1'b0;
    data_req = 1'b0;
    repeat (2) @(negedge clk);
    end_test("reset");

    repeat (40) instr_read(rand_word_addr());
    wait_idle();
    end_test("instr_reads");

    repeat (40) begin
      a = rand_word_addr();
      data_access(1'b1, a, 4'($random(seed)), $random(seed));
      data_access(1'b0, a, 4'hf, '0);
    end
    wait_idle();
    end_test("masked_writes");

    fork
      repeat (30) instr_read(rand_word_addr());
      repeat (30) data_access(1'($random(seed)), rand_word_addr(), 4'($random(seed)),
                              $random(seed));
    join
    wait_idle();
    u_checker.check_balance();
    end_test("back_pressure");

    max_delay = 1'b1;
    fork
      repeat (20) instr_read(rand_word_addr());
      repeat (20) data_access(1'b0, rand_word_addr(), 4'hf, '0);
    join
    wait_idle();
    max_delay = 1'b0;
    end_test("outstanding_limit");

    repeat (4) begin
      a = rand_word_addr();
      data_access(1'b1, a | 32'h8000_0000, 4'hf, $random(seed));
      data_access(1'b0, a | 32'h8000_0000, 4'hf, '0);
      data_access(1'b0, a, 4'hf, '0);
      instr_read(a | 32'h8000_0000);
    end
    wait_idle();
    end_test("error_region");

    $display("tests run %0d, tests failed %0d, errors %0d", tests, tests_failed,
             u_checker.errors);
    if (u_checker.errors == 0) begin
      $display("TEST RESULT: PASS");
    end else begin
      $display("TEST RESULT: FAIL");
    end
    $finish;
  end

endmodule

//--- sim.f
tlul_pkg.sv
tlul_outstanding_fifo.sv
tlul_rsp_check.sv
tlul_host_adapter.sv
tlul_host_wrapper.sv
tb_tlul_checker.sv
tb_tlul_host_wrapper.sv

//--- Makefile
VERILATOR ?= verilator
TOP       ?= tb_tlul_host_wrapper
FILELIST  ?= sim.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing -Wno-fatal

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "TEST RESULT: PASS"

clean:
	rm -rf $(BUILD_DIR)
